//--- src.f
verilog/cpu_pkg.sv
verilog/pipeline_control.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/retire_stage.sv
verilog/cpu_top.sv
tb/cpu_checker.sv
tb/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_top.sv
module tb_top;
  import cpu_pkg::*;

  localparam int PROG_WORDS = 128;
  localparam int DONE_LIMIT = 8000;

  logic              clk = 1'b0;
  logic              rst_n;
  instr_t            inst_rdata;
  logic              ready;
  logic              mem_start_ready;
  logic [IN_W-1:0]   data_in;
  logic [XLEN-1:0]   pc;
  logic [OUT_W-1:0]  data_out;
  logic              out_valid;
  logic [XLEN-1:0]   prog [PROG_WORDS];
  int                plen;
  bit                stall_en;
  logic              check_start;
  int                test_id;
  logic              check_done;
  int                fail_count;
  int                tests_run;
  bit                hung;
  int                d;

  always #5 clk = ~clk;

  cpu_top #(.RESET_PC('0), .NUM_REGS(64)) DUT (
    .clk, .rst_n, .inst_rdata, .ready, .mem_start_ready, .data_in,
    .pc, .data_out, .out_valid
  );

  cpu_checker #(.PROG_WORDS(PROG_WORDS)) u_checker (
    .clk, .out_valid, .data_out, .start(check_start), .test_id, .din(data_in),
    .prog, .done(check_done), .fail_count
  );

  // Instruction memory with random wait cycles when enabled.
  always @(negedge clk) begin
    ready      <= stall_en ? ($urandom_range(3) != 0) : 1'b1;
    inst_rdata <= ((pc >> 2) < PROG_WORDS) ? prog[pc[8:2]] : NOP_INSTR;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Assembler.
  function automatic logic [31:0] enc(input logic wi, input logic [5:0] w, input logic ai,
                                      input logic [5:0] a, input logic bi, input logic [5:0] b,
                                      input logic [3:0] f, input opcode_e o);
    return {wi, w, 1'b0, ai, a, bi, b, f, o};
  endfunction

  function automatic logic [31:0] alu_rr(input logic [3:0] f, input logic [5:0] w,
                                         input logic [5:0] a, input logic [5:0] b);
    return enc(1'b0, w, 1'b0, a, 1'b0, b, f, OPC_ALU);
  endfunction

  function automatic logic [31:0] alu_ri(input logic [3:0] f, input logic [5:0] w,
                                         input logic [5:0] a, input logic [5:0] imm);
    return enc(1'b0, w, 1'b0, a, 1'b1, imm, f, OPC_ALU);
  endfunction

  function automatic logic [31:0] out_reg(input logic [5:0] r);
    return enc(1'b0, r, 1'b0, r, 1'b0, r, FN_SND, OPC_OUT);
  endfunction

  function automatic logic [31:0] ldc(input logic [5:0] w, input logic [22:0] val,
                                      input logic neg);
    return {1'b1, w, 1'b1, neg, val};
  endfunction

  function automatic logic [31:0] ldu(input logic [5:0] w, input logic [8:0] val);
    return {1'b0, w, 1'b1, 15'd0, val};
  endfunction

  // Offset is in bytes from the branch itself.
  function automatic logic [31:0] branch(input opcode_e o, input logic [5:0] off,
                                         input logic [5:0] b);
    return enc(1'b1, off, 1'b1, 6'd0, 1'b0, b, FN_SND, o);
  endfunction

  task automatic clear_prog();
    int i;
    for (i = 0; i < PROG_WORDS; i++) begin
      prog[i] = {7'(i), 19'd0, 6'd63}; // Unused words decode as NOP and carry their index.
    end
    plen = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    prog[plen] = word;
    plen++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Programs.
  task automatic build_alu();
    int f;
    clear_prog();
    emit(ldc(1, 23'd1000, 1'b0));
    emit(ldc(2, 23'd300, 1'b0));
    emit(ldc(3, 23'd1, 1'b1));
    emit(ldc(9, 23'h7FFFFF, 1'b0));
    emit(ldu(9, 9'h0FF));
    emit(alu_ri(FN_ADD, 4, 3, 6'd1)); // Carry out.
    emit(out_reg(4));
    emit(alu_rr(FN_CARRY, 5, 0, 0));
    emit(out_reg(5));
    emit(alu_rr(FN_ADC, 6, 1, 2));
    emit(out_reg(6));
    emit(alu_ri(FN_ADD, 7, 9, 6'd1)); // Signed overflow.
    emit(out_reg(7));
    emit(alu_rr(FN_OVERFLOW, 8, 0, 0));
    emit(out_reg(8));
    for (f = 0; f < 16; f++) begin
      emit(alu_rr(4'(f), 10, 1, 2));
      emit(out_reg(10));
      emit(alu_ri(4'(f), 11, 1, 6'h3B));
      emit(out_reg(11));
    end
  endtask

  task automatic build_shift();
    int p;
    int k;
    clear_prog();
    for (p = 0; p < 4; p++) begin
      emit(ldc(1, 23'($urandom), 1'($urandom)));
      emit(ldc(2, 23'($urandom_range(31)), 1'b0));
      for (k = 0; k < 4; k++) begin
        emit(enc(1'b0, 3, 1'b0, 1, 1'b0, 2, 4'(k), OPC_SHIFT));
        emit(out_reg(3));
      end
      emit(enc(1'b0, 4, 1'b0, 1, 1'b1, 6'd7, 4'd2, OPC_SHIFT));
      emit(out_reg(4));
    end
  endtask

  task automatic build_forward();
    clear_prog();
    emit(ldc(1, 23'd5, 1'b0));
    emit(alu_rr(FN_ADD, 2, 1, 1));
    emit(alu_rr(FN_ADD, 3, 2, 1));
    emit(alu_rr(FN_MUL, 4, 3, 2));
    emit(out_reg(4));
    emit(enc(1'b0, 5, 1'b0, 4, 1'b1, 6'd3, 4'd0, OPC_SHIFT));
    emit(alu_rr(FN_SUB, 6, 5, 1));
    emit(out_reg(6));
    emit(enc(1'b0, 7, 1'b1, 0, 1'b1, 0, FN_AND, OPC_IN));
    emit(alu_rr(FN_XOR, 8, 7, 6));
    emit(out_reg(8));
    emit(enc(1'b0, 9, 1'b1, 6'd4, 1'b1, 0, FN_ADD, OPC_JUMP));
    emit(alu_rr(FN_ADD, 10, 9, 9)); // Link value arrives through the decode bypass.
    emit(out_reg(10));
    emit(ldc(11, 23'd77, 1'b0));
    emit(NOP_INSTR);
    emit(NOP_INSTR);
    emit(alu_ri(FN_ADD, 12, 11, 6'd1)); // Read in decode during writeback.
    emit(out_reg(12));
    emit(ldc(13, 23'd3, 1'b0));
    emit(NOP_INSTR);
    emit(alu_rr(FN_ADD, 14, 13, 13));
    emit(out_reg(14));
    emit(ldc(15, 23'd100, 1'b0));
    emit(ldu(15, 9'd1));
    emit(enc(1'b0, 16, 1'b0, 15, 1'b1, 6'd20, 4'd1, OPC_SHIFT));
    emit(out_reg(16));
  endtask

  task automatic build_branch();
    clear_prog();
    emit(ldc(1, 23'd0, 1'b0));
    emit(ldc(2, 23'd3, 1'b0));
    emit(branch(OPC_JZ, 6'd12, 1)); // Taken.
    emit(out_reg(2));
    emit(out_reg(2));
    emit(branch(OPC_JZ, 6'd12, 2));
    emit(out_reg(2));
    emit(branch(OPC_JNZ, 6'd12, 2)); // Taken.
    emit(out_reg(1));
    emit(out_reg(1));
    emit(branch(OPC_JNZ, 6'd12, 1));
    emit(out_reg(1));
    emit(enc(1'b0, 3, 1'b1, 6'd12, 1'b1, 0, FN_ADD, OPC_JUMP));
    emit(out_reg(2));
    emit(out_reg(2));
    emit(out_reg(3));
    emit(ldc(4, 23'd3, 1'b0));
    emit(alu_rr(FN_DEC, 4, 4, 4));
    emit(out_reg(4));
    emit(branch(OPC_JNZ, 6'h38, 4)); // Back two instructions.
  endtask

  task automatic build_const();
    clear_prog();
    emit(ldc(1, 23'd12345, 1'b0));
    emit(out_reg(1));
    emit(ldc(2, 23'd1000, 1'b1));
    emit(out_reg(2));
    emit(ldc(3, 23'h7ABCDE, 1'b0));
    emit(ldu(3, 9'h1A5));
    emit(enc(1'b0, 4, 1'b0, 3, 1'b1, 6'd23, 4'd1, OPC_SHIFT));
    emit(out_reg(4));
    emit(out_reg(3));
    emit(enc(1'b0, 5, 1'b1, 0, 1'b1, 0, FN_AND, OPC_IN));
    emit(out_reg(5));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_test(input int id, input bit stalls, input logic [IN_W-1:0] din);
    int t;
    if (hung) return;
    @(negedge clk);
    stall_en    = stalls;
    data_in     = din;
    test_id     = id;
    rst_n       = 1'b0;
    check_start = 1'b1;
    @(negedge clk);
    check_start = 1'b0;
    @(negedge clk);
    rst_n           = 1'b1;
    mem_start_ready = 1'b1;
    @(negedge clk);
    mem_start_ready = 1'b0;
    for (t = 0; t < DONE_LIMIT && !check_done; t++) @(negedge clk);
    tests_run++;
    if (!check_done) begin
      $display("checker gave no result for test %0d within %0d cycles", id, DONE_LIMIT);
      hung = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(42));
    rst_n           = 1'b0;
    ready           = 1'b1;
    mem_start_ready = 1'b0;
    data_in         = '0;
    inst_rdata      = NOP_INSTR;
    stall_en        = 1'b0;
    check_start     = 1'b0;
    test_id         = 0;
    tests_run       = 0;
    hung            = 1'b0;
    build_alu();
    run_test(0, 1'b0, 2'd0);
    build_shift();
    run_test(1, 1'b0, 2'd0);
    build_forward();
    run_test(2, 1'b0, 2'd2);
    build_branch();
    run_test(3, 1'b0, 2'd0);
    for (d = 0; d < 4; d++) begin
      build_const();
      run_test(4 + d, 1'b0, 2'(d));
    end
    build_alu();
    run_test(8, 1'b1, 2'd0); // Same program under ready stalls.
    $display("tests run %0d, failed %0d", tests_run, fail_count);
    if (!hung && fail_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb/cpu_checker.sv
module cpu_checker #(
  parameter int PROG_WORDS = 128
) (
  input  logic                      clk,
  input  logic                      out_valid,
  input  logic [cpu_pkg::OUT_W-1:0] data_out,
  input  logic                      start,
  input  int                        test_id,
  input  logic [cpu_pkg::IN_W-1:0]  din,
  input  logic [cpu_pkg::XLEN-1:0]  prog [PROG_WORDS],
  output logic                      done,
  output int                        fail_count
);
  import cpu_pkg::*;

  localparam int OUT_LIMIT = 5000;
  localparam int QUIET     = 40;
  localparam int MAX_STEPS = 4000;

  logic [OUT_W-1:0] exp_vals [$];
  logic [OUT_W-1:0] got_vals [$];

  function automatic logic [XLEN-1:0] sext6(input logic [5:0] val);
    return {{(XLEN-6){val[5]}}, val};
  endfunction

  function automatic string test_label(input int id);
    case (id)
      0:       return "alu_ops";
      1:       return "shifts";
      2:       return "forwarding";
      3:       return "branches";
      8:       return "alu_ops_stalled";
      default: return $sformatf("const_in_%0d", id - 4);
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequential ISA model without a pipeline.
  function automatic void model_program(input logic [IN_W-1:0] d);
    logic [XLEN-1:0]   r [64];
    instr_t            ins;
    opcode_e           o;
    logic [3:0]        fn;
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   w;
    logic [XLEN-1:0]   x;
    logic [XLEN-1:0]   y;
    logic [XLEN-1:0]   res;
    logic [XLEN-1:0]   sres;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   npc;
    logic [XLEN:0]     sum;
    logic [2*XLEN-1:0] prod;
    logic [2*XLEN-1:0] rot;
    logic              c;
    logic              v;
    int                i;
    int                steps;
    exp_vals.delete();
    c     = 1'b0;
    v     = 1'b0;
    pc    = '0;
    steps = 0;
    for (i = 0; i < 64; i++) r[i] = '0;
    while ((pc >> 2) < PROG_WORDS && steps < MAX_STEPS) begin
      ins = prog[pc[8:2]];
      steps++;
      if (ins.const_flag) begin
        o = ins.w_imm ? OPC_LOADCONST : ((ins[23:9] == '0) ? OPC_LOADUPPER : OPC_NOP);
      end else if (ins.opc inside {OPC_ALU, OPC_SHIFT, OPC_OUT, OPC_IN, OPC_JUMP, OPC_JZ,
                                   OPC_JNZ}) begin
        o = opcode_e'(ins.opc);
      end else begin
        o = OPC_NOP;
      end
      if (o inside {OPC_ALU, OPC_OUT, OPC_JUMP, OPC_JZ, OPC_JNZ}) fn = ins.func;
      else if (o == OPC_SHIFT) fn = 4'd12 + {2'b00, ins.func[1:0]};
      else fn = FN_AND;
      a = ins.a_imm ? sext6(ins.addr_a) : r[ins.addr_a];
      b = ins.b_imm ? sext6(ins.addr_b) : r[ins.addr_b];
      w = ins.w_imm ? sext6(ins.addr_w) : r[ins.addr_w];
      x = (o == OPC_JUMP) ? pc : a;
      y = (o == OPC_JUMP) ? a : b;
      sum  = {1'b0, x} + {1'b0, y} + ((fn == FN_ADC) ? (XLEN+1)'(c) : '0);
      prod = {{XLEN{1'b0}}, x} * {{XLEN{1'b0}}, y};
      case (fn)
        FN_ADD, FN_ADC: res = sum[XLEN-1:0];
        FN_SUB:         res = x - y;
        FN_CARRY:       res = XLEN'(c);
        FN_OVERFLOW:    res = XLEN'(v);
        FN_INC:         res = x + 1;
        FN_DEC:         res = x - 1;
        FN_MUL:         res = prod[XLEN-1:0];
        FN_MULH:        res = prod[2*XLEN-1:XLEN];
        FN_AND:         res = x & y;
        FN_OR:          res = x | y;
        FN_XOR:         res = x ^ y;
        FN_EQ:          res = XLEN'(x == y);
        FN_LT:          res = XLEN'($signed(x) < $signed(y));
        FN_LTU:         res = XLEN'(x < y);
        default:        res = y;
      endcase
      if (fn == FN_ADD || fn == FN_ADC) c = sum[XLEN];
      if (fn == FN_ADD) v = (x[XLEN-1] == y[XLEN-1]) && (res[XLEN-1] != x[XLEN-1]);
      else if (fn == FN_SUB) v = (x[XLEN-1] != y[XLEN-1]) && (res[XLEN-1] != x[XLEN-1]);
      rot = {a, a} >> b[4:0];
      case (fn[1:0])
        2'd0:    sres = a << b[4:0];
        2'd1:    sres = a >> b[4:0];
        2'd2:    sres = $signed(a) >>> b[4:0];
        default: sres = rot[XLEN-1:0]; // Rotate right.
      endcase
      npc = pc + 4;
      case (o)
        OPC_ALU, OPC_OUT: r[ins.addr_w] = res;
        OPC_SHIFT:        r[ins.addr_w] = sres;
        OPC_IN:           r[ins.addr_w] = XLEN'(d);
        OPC_JUMP: begin
          r[ins.addr_w] = pc + 4;
          npc = res;
        end
        OPC_JZ:           if (res == '0) npc = pc + w;
        OPC_JNZ:          if (res != '0) npc = pc + w;
        OPC_LOADCONST:    r[ins.addr_w] = ins.a_imm ? '0 - XLEN'(ins[22:0]) : XLEN'(ins[22:0]);
        OPC_LOADUPPER:    r[ins.addr_w] = {ins[8:0], w[22:0]};
        default: ;
      endcase
      if (o == OPC_OUT) exp_vals.push_back(res[OUT_W-1:0]);
      pc = npc;
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Observed OUT values in order.
  always @(negedge clk) begin
    if (out_valid) got_vals.push_back(data_out);
  end

  task automatic check_test();
    int    t;
    int    i;
    int    n;
    int    errs;
    string name;
    name = test_label(test_id);
    model_program(din);
    got_vals.delete();
    n    = exp_vals.size();
    errs = 0;
    for (t = 0; t < OUT_LIMIT && got_vals.size() < n; t++) @(posedge clk);
    if (got_vals.size() < n) begin
      $display("%s: timed out with %0d of %0d outputs seen", name, got_vals.size(), n);
      errs++;
    end
    for (t = 0; t < QUIET && got_vals.size() <= n; t++) @(posedge clk); // Catch extras.
    if (got_vals.size() > n) begin
      $display("%s: %0d outputs seen where %0d were expected", name, got_vals.size(), n);
      errs++;
    end
    for (i = 0; i < n && i < got_vals.size(); i++) begin
      if (got_vals[i] != exp_vals[i]) begin
        $display("[ERROR] %s: output %0d expected 0x%03h actual 0x%03h", name, i,
                 exp_vals[i], got_vals[i]);
        errs++;
      end
    end
    if (errs == 0) $display("%s: ok, %0d outputs", name, n);
    else $display("%s: failed with %0d errors", name, errs);
    if (errs != 0) fail_count++;
    done = 1'b1;
    @(posedge clk);
    done = 1'b0;
  endtask

  initial begin
    done       = 1'b0;
    fail_count = 0;
    forever begin
      @(posedge clk);
      if (start) check_test();
    end
  end

endmodule

//--- verilog/cpu_top.sv
module cpu_top #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0,
  parameter int                       NUM_REGS = 64
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cpu_pkg::instr_t           inst_rdata,
  input  logic                      ready,
  input  logic                      mem_start_ready,
  input  logic [cpu_pkg::IN_W-1:0]  data_in,
  output logic [cpu_pkg::XLEN-1:0]  pc,
  output logic [cpu_pkg::OUT_W-1:0] data_out,
  output logic                      out_valid
);
  import cpu_pkg::*;

  logic                  advance;
  logic                  flush;
  fwd_sel_e              fwd_a;
  fwd_sel_e              fwd_b;
  fwd_sel_e              fwd_w;
  logic                  jump_taken;
  logic [XLEN-1:0]       jump_addr;
  instr_t                id_instr;
  logic [XLEN-1:0]       id_pc;
  logic [REG_ADDR_W-1:0] addr_a;
  logic [REG_ADDR_W-1:0] addr_b;
  logic [REG_ADDR_W-1:0] addr_w;
  logic [XLEN-1:0]       rd_a;
  logic [XLEN-1:0]       rd_b;
  logic [XLEN-1:0]       rd_w;
  id_ex_t                ex_pipe;
  ex_mem_t               mem_pipe;
  wb_t                   wb;
  logic [XLEN-1:0]       mem_alu;
  logic [XLEN-1:0]       mem_shift;
  logic [XLEN-1:0]       mem_link;
  logic [XLEN-1:0]       mem_imm;

  pipeline_control u_control (
    .clk, .rst_n, .ready, .mem_start_ready, .jump_taken,
    .ex_pipe, .mem_pipe, .wb,
    .advance, .flush, .fwd_a, .fwd_b, .fwd_w
  );

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .clk, .rst_n, .advance, .flush, .jump_taken, .jump_addr,
    .inst_rdata, .pc, .id_instr, .id_pc
  );

  register_file #(.NUM_REGS(NUM_REGS)) u_regs (
    .clk, .addr_a, .addr_b, .addr_w, .wb, .rd_a, .rd_b, .rd_w
  );

  decode_stage u_decode (
    .clk, .rst_n, .advance, .flush, .id_instr, .id_pc,
    .rd_a, .rd_b, .rd_w, .wb, .addr_a, .addr_b, .addr_w, .ex_pipe
  );

  execute_stage u_execute (
    .clk, .rst_n, .advance, .ex_pipe, .fwd_a, .fwd_b, .fwd_w, .wb,
    .mem_alu, .mem_shift, .mem_link, .mem_imm,
    .jump_taken, .jump_addr, .mem_pipe
  );

  retire_stage u_retire (
    .clk, .rst_n, .advance, .mem_pipe, .data_in,
    .mem_alu, .mem_shift, .mem_link, .mem_imm,
    .wb, .data_out, .out_valid
  );

endmodule

//--- verilog/retire_stage.sv
module retire_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      advance,
  input  cpu_pkg::ex_mem_t          mem_pipe,
  input  logic [cpu_pkg::IN_W-1:0]  data_in,
  output logic [cpu_pkg::XLEN-1:0]  mem_alu,
  output logic [cpu_pkg::XLEN-1:0]  mem_shift,
  output logic [cpu_pkg::XLEN-1:0]  mem_link,
  output logic [cpu_pkg::XLEN-1:0]  mem_imm,
  output cpu_pkg::wb_t              wb,
  output logic [cpu_pkg::OUT_W-1:0] data_out,
  output logic                      out_valid
);
  import cpu_pkg::*;

  ex_mem_t         wb_q;
  logic [XLEN-1:0] wb_data;

  // Memory-slot values for forwarding. IN forwards the live input level.
  assign mem_alu   = (mem_pipe.opc == OPC_IN) ? XLEN'(data_in) : mem_pipe.alu_res;
  assign mem_shift = mem_pipe.shift_res;
  assign mem_link  = mem_pipe.pc + 32'd4;
  assign mem_imm   = (mem_pipe.opc == OPC_LOADUPPER) ? {mem_pipe.imm[8:0], mem_pipe.data_w[22:0]}
                                                     : mem_pipe.imm;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_q.opc       <= OPC_NOP;
      wb_q.write_reg <= 1'b0;
    end else if (advance) begin
      wb_q     <= mem_pipe;
      wb_q.imm <= mem_imm; // Upper bits merged.
    end
  end

  always_comb begin
    case (wb_q.opc)
      OPC_SHIFT:                    wb_data = wb_q.shift_res;
      OPC_IN:                       wb_data = XLEN'(data_in);
      OPC_JUMP:                     wb_data = wb_q.pc + 32'd4;
      OPC_LOADCONST, OPC_LOADUPPER: wb_data = wb_q.imm;
      default:                      wb_data = wb_q.alu_res;
    endcase
  end

  assign wb = '{we: wb_q.write_reg && advance, addr: wb_q.addr_w, data: wb_data};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= advance && (wb_q.opc == OPC_OUT); // One pulse per OUT.
    end
  end

  always_ff @(posedge clk) begin
    if (advance && (wb_q.opc == OPC_OUT)) begin
      data_out <= wb_q.alu_res[OUT_W-1:0];
    end
  end

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     advance,
  input  cpu_pkg::id_ex_t          ex_pipe,
  input  cpu_pkg::fwd_sel_e        fwd_a,
  input  cpu_pkg::fwd_sel_e        fwd_b,
  input  cpu_pkg::fwd_sel_e        fwd_w,
  input  cpu_pkg::wb_t             wb,
  input  logic [cpu_pkg::XLEN-1:0] mem_alu,
  input  logic [cpu_pkg::XLEN-1:0] mem_shift,
  input  logic [cpu_pkg::XLEN-1:0] mem_link,
  input  logic [cpu_pkg::XLEN-1:0] mem_imm,
  output logic                     jump_taken,
  output logic [cpu_pkg::XLEN-1:0] jump_addr,
  output cpu_pkg::ex_mem_t         mem_pipe
);
  import cpu_pkg::*;

  logic [XLEN-1:0]   a;
  logic [XLEN-1:0]   b;
  logic [XLEN-1:0]   w;
  logic [XLEN-1:0]   in1;
  logic [XLEN-1:0]   in2;
  logic [XLEN:0]     sum;
  logic [XLEN-1:0]   diff;
  logic [2*XLEN-1:0] prod;
  logic [XLEN-1:0]   alu_res;
  logic [XLEN-1:0]   shift_res;
  logic [4:0]        sh;
  logic              carry_q;
  logic              overflow_q;
  logic              add_ovf;
  logic              sub_ovf;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_e sel, input logic [XLEN-1:0] own);
    case (sel)
      FWD_WB:        return wb.data;
      FWD_MEM_ALU:   return mem_alu;
      FWD_MEM_SHIFT: return mem_shift;
      FWD_MEM_LINK:  return mem_link;
      FWD_MEM_IMM:   return mem_imm;
      default:       return own;
    endcase
  endfunction

  always_comb begin
    a = fwd_mux(fwd_a, ex_pipe.data_a);
    b = fwd_mux(fwd_b, ex_pipe.data_b);
    w = fwd_mux(fwd_w, ex_pipe.data_w);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU.
  always_comb begin
    in1     = (ex_pipe.opc == OPC_JUMP) ? ex_pipe.pc : a; // JUMP computes PC + A.
    in2     = (ex_pipe.opc == OPC_JUMP) ? a : b;
    sum     = {1'b0, in1} + {1'b0, in2} + (XLEN+1)'((ex_pipe.func == FN_ADC) && carry_q);
    diff    = in1 - in2;
    prod    = {{XLEN{1'b0}}, in1} * {{XLEN{1'b0}}, in2};
    add_ovf = (in1[XLEN-1] == in2[XLEN-1]) && (sum[XLEN-1] != in1[XLEN-1]);
    sub_ovf = (in1[XLEN-1] != in2[XLEN-1]) && (diff[XLEN-1] != in1[XLEN-1]);
    case (ex_pipe.func)
      FN_ADD, FN_ADC: alu_res = sum[XLEN-1:0];
      FN_SUB:         alu_res = diff;
      FN_CARRY:       alu_res = XLEN'(carry_q);
      FN_OVERFLOW:    alu_res = XLEN'(overflow_q);
      FN_INC:         alu_res = in1 + 32'd1;
      FN_DEC:         alu_res = in1 - 32'd1;
      FN_MUL:         alu_res = prod[XLEN-1:0];
      FN_MULH:        alu_res = prod[2*XLEN-1:XLEN];
      FN_AND:         alu_res = in1 & in2;
      FN_OR:          alu_res = in1 | in2;
      FN_XOR:         alu_res = in1 ^ in2;
      FN_EQ:          alu_res = XLEN'(in1 == in2);
      FN_LT:          alu_res = XLEN'($signed(in1) < $signed(in2));
      FN_LTU:         alu_res = XLEN'(in1 < in2);
      default:        alu_res = in2;
    endcase
  end

  // Sticky flags.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      carry_q    <= 1'b0;
      overflow_q <= 1'b0;
    end else if (advance) begin
      if (ex_pipe.func inside {FN_ADD, FN_ADC}) begin
        carry_q <= sum[XLEN];
      end
      if (ex_pipe.func == FN_ADD) begin
        overflow_q <= add_ovf;
      end else if (ex_pipe.func == FN_SUB) begin
        overflow_q <= sub_ovf;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shifter and branch.
  always_comb begin
    sh = b[4:0];
    case (ex_pipe.func[1:0])
      2'd0:    shift_res = a << sh;
      2'd1:    shift_res = a >> sh;
      2'd2:    shift_res = $signed(a) >>> sh;
      default: shift_res = (a >> sh) | (a << (XLEN - int'(sh)));
    endcase
  end

  always_comb begin
    jump_taken = (ex_pipe.opc == OPC_JUMP)
              || ((ex_pipe.opc == OPC_JZ) && (alu_res == '0))
              || ((ex_pipe.opc == OPC_JNZ) && (alu_res != '0));
    jump_addr  = (ex_pipe.opc == OPC_JUMP) ? alu_res : ex_pipe.pc + w;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_pipe.opc       <= OPC_NOP;
      mem_pipe.write_reg <= 1'b0;
    end else if (advance) begin
      mem_pipe.pc        <= ex_pipe.pc;
      mem_pipe.data_w    <= w;
      mem_pipe.imm       <= ex_pipe.imm;
      mem_pipe.alu_res   <= alu_res;
      mem_pipe.shift_res <= shift_res;
      mem_pipe.addr_w    <= ex_pipe.addr_w;
      mem_pipe.opc       <= ex_pipe.opc;
      mem_pipe.write_reg <= ex_pipe.opc inside {OPC_ALU, OPC_SHIFT, OPC_OUT, OPC_IN, OPC_JUMP,
                                                OPC_LOADCONST, OPC_LOADUPPER};
    end
  end

endmodule

//--- verilog/decode_stage.sv
module decode_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           advance,
  input  logic                           flush,
  input  cpu_pkg::instr_t                id_instr,
  input  logic [cpu_pkg::XLEN-1:0]       id_pc,
  input  logic [cpu_pkg::XLEN-1:0]       rd_a,
  input  logic [cpu_pkg::XLEN-1:0]       rd_b,
  input  logic [cpu_pkg::XLEN-1:0]       rd_w,
  input  cpu_pkg::wb_t                   wb,
  output logic [cpu_pkg::REG_ADDR_W-1:0] addr_a,
  output logic [cpu_pkg::REG_ADDR_W-1:0] addr_b,
  output logic [cpu_pkg::REG_ADDR_W-1:0] addr_w,
  output cpu_pkg::id_ex_t                ex_pipe
);
  import cpu_pkg::*;

  opcode_e         dec_opc;
  alu_func_e       dec_func;
  logic [XLEN-1:0] dec_imm;

  // Immediate, or register value with the same-cycle writeback bypassed in.
  function automatic logic [XLEN-1:0] src_value(input logic imm_flag,
                                                input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rd, input wb_t wbk);
    logic hit;
    hit = wbk.we && (wbk.addr == addr);
    if (imm_flag) begin
      return {{(XLEN-REG_ADDR_W){addr[REG_ADDR_W-1]}}, addr};
    end
    return hit ? wbk.data : rd;
  endfunction

  assign addr_a = id_instr.addr_a;
  assign addr_b = id_instr.addr_b;
  assign addr_w = id_instr.addr_w;

  always_comb begin
    if (id_instr.const_flag) begin
      if (id_instr.w_imm) begin
        dec_opc = OPC_LOADCONST;
      end else if (id_instr[23:9] == '0) begin
        dec_opc = OPC_LOADUPPER;
      end else begin
        dec_opc = OPC_NOP;
      end
    end else begin
      case (id_instr.opc)
        OPC_ALU, OPC_SHIFT, OPC_OUT, OPC_IN, OPC_JUMP, OPC_JZ, OPC_JNZ:
          dec_opc = opcode_e'(id_instr.opc);
        default: dec_opc = OPC_NOP; // Dropped opcodes land here too.
      endcase
    end
  end

  always_comb begin
    case (dec_opc)
      OPC_ALU, OPC_OUT, OPC_JUMP, OPC_JZ, OPC_JNZ: dec_func = alu_func_e'(id_instr.func);
      OPC_SHIFT: dec_func = alu_func_e'({2'b11, id_instr.func[1:0]});
      default:   dec_func = FN_AND;
    endcase
  end

  always_comb begin
    dec_imm = '0;
    if (dec_opc == OPC_LOADCONST) begin
      dec_imm = XLEN'(id_instr[22:0]);
      if (id_instr.a_imm) begin
        dec_imm = '0 - dec_imm; // Bit 23 negates.
      end
    end else if (dec_opc == OPC_LOADUPPER) begin
      dec_imm = XLEN'(id_instr[8:0]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_pipe.opc  <= OPC_NOP;
      ex_pipe.func <= FN_AND;
    end else if (advance) begin
      ex_pipe.pc     <= id_pc;
      ex_pipe.data_a <= src_value(id_instr.a_imm, id_instr.addr_a, rd_a, wb);
      ex_pipe.data_b <= src_value(id_instr.b_imm, id_instr.addr_b, rd_b, wb);
      ex_pipe.data_w <= src_value(id_instr.w_imm, id_instr.addr_w, rd_w, wb);
      ex_pipe.imm    <= dec_imm;
      ex_pipe.addr_a <= id_instr.addr_a;
      ex_pipe.addr_b <= id_instr.addr_b;
      ex_pipe.addr_w <= id_instr.addr_w;
      ex_pipe.a_dis  <= id_instr.a_imm;
      ex_pipe.b_dis  <= id_instr.b_imm;
      ex_pipe.w_dis  <= id_instr.w_imm;
      ex_pipe.opc    <= flush ? OPC_NOP : dec_opc;
      ex_pipe.func   <= flush ? FN_AND : dec_func;
    end
  end

endmodule

//--- verilog/register_file.sv
module register_file #(
  parameter int NUM_REGS = 64
) (
  input  logic                           clk,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] addr_a,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] addr_b,
  input  logic [cpu_pkg::REG_ADDR_W-1:0] addr_w,
  input  cpu_pkg::wb_t                   wb,
  output logic [cpu_pkg::XLEN-1:0]       rd_a,
  output logic [cpu_pkg::XLEN-1:0]       rd_b,
  output logic [cpu_pkg::XLEN-1:0]       rd_w
);
  import cpu_pkg::*;

  logic [XLEN-1:0] regs [NUM_REGS] = '{default: '0}; // Starts cleared.

  always_ff @(posedge clk) begin
    if (wb.we) begin
      regs[wb.addr] <= wb.data;
    end
  end

  assign rd_a = regs[addr_a];
  assign rd_b = regs[addr_b];
  assign rd_w = regs[addr_w];

endmodule

//--- verilog/fetch_stage.sv
module fetch_stage #(
  parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     advance,
  input  logic                     flush,
  input  logic                     jump_taken,
  input  logic [cpu_pkg::XLEN-1:0] jump_addr,
  input  cpu_pkg::instr_t          inst_rdata,
  output logic [cpu_pkg::XLEN-1:0] pc,
  output cpu_pkg::instr_t          id_instr,
  output logic [cpu_pkg::XLEN-1:0] id_pc
);
  import cpu_pkg::*;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc       <= RESET_PC;
      id_instr <= NOP_INSTR;
    end else if (advance) begin
      pc       <= jump_taken ? jump_addr : pc + 32'd4;
      id_instr <= flush ? NOP_INSTR : inst_rdata; // Younger fetch is squashed.
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id_pc <= pc;
    end
  end

endmodule

//--- verilog/pipeline_control.sv
module pipeline_control (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ready,
  input  logic              mem_start_ready,
  input  logic              jump_taken,
  input  cpu_pkg::id_ex_t   ex_pipe,
  input  cpu_pkg::ex_mem_t  mem_pipe,
  input  cpu_pkg::wb_t      wb,
  output logic              advance,
  output logic              flush,
  output cpu_pkg::fwd_sel_e fwd_a,
  output cpu_pkg::fwd_sel_e fwd_b,
  output cpu_pkg::fwd_sel_e fwd_w
);
  import cpu_pkg::*;

  run_state_e state;
  logic       use_a;
  logic       use_b;
  logic       use_w;

  // Memory-slot producer wins over writeback.
  function automatic fwd_sel_e pick(input logic [REG_ADDR_W-1:0] addr, input logic use_reg,
                                    input ex_mem_t mem, input wb_t wbk);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (use_reg && mem.write_reg && (mem.addr_w == addr)) begin
      case (mem.opc)
        OPC_SHIFT:                    sel = FWD_MEM_SHIFT;
        OPC_JUMP:                     sel = FWD_MEM_LINK;
        OPC_LOADCONST, OPC_LOADUPPER: sel = FWD_MEM_IMM;
        default:                      sel = FWD_MEM_ALU; // ALU, OUT and IN.
      endcase
    end else if (use_reg && wbk.we && (wbk.addr == addr)) begin
      sel = FWD_WB;
    end
    return sel;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= WAIT_START;
    end else if ((state == WAIT_START) && mem_start_ready) begin
      state <= RUN;
    end
  end

  assign advance = (state == RUN) && ready; // Ready low freezes everything.
  assign flush   = advance && jump_taken;

  always_comb begin
    use_a = !ex_pipe.a_dis && (ex_pipe.opc inside {OPC_ALU, OPC_SHIFT, OPC_OUT, OPC_JUMP,
                                                   OPC_JZ, OPC_JNZ});
    use_b = !ex_pipe.b_dis && (ex_pipe.opc inside {OPC_ALU, OPC_SHIFT, OPC_OUT,
                                                   OPC_JZ, OPC_JNZ});
    use_w = !ex_pipe.w_dis && (ex_pipe.opc inside {OPC_JZ, OPC_JNZ, OPC_LOADUPPER});
    fwd_a = pick(ex_pipe.addr_a, use_a, mem_pipe, wb);
    fwd_b = pick(ex_pipe.addr_b, use_b, mem_pipe, wb);
    fwd_w = pick(ex_pipe.addr_w, use_w, mem_pipe, wb);
  end

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 6;
  localparam int OUT_W      = 10;
  localparam int IN_W       = 2;

  localparam logic [XLEN-1:0] NOP_INSTR = 32'd63;

  typedef enum logic [5:0] {
    OPC_ALU       = 6'd0,
    OPC_SHIFT     = 6'd1,
    OPC_OUT       = 6'd6,
    OPC_IN        = 6'd7,
    OPC_JUMP      = 6'd9,
    OPC_JZ        = 6'd10,
    OPC_JNZ       = 6'd11,
    OPC_LOADCONST = 6'd13,
    OPC_LOADUPPER = 6'd14,
    OPC_NOP       = 6'd15
  } opcode_e;

  typedef enum logic [3:0] {
    FN_ADD, FN_ADC, FN_SUB, FN_CARRY, FN_OVERFLOW, FN_INC, FN_DEC, FN_MUL,
    FN_MULH, FN_AND, FN_OR, FN_XOR, FN_EQ, FN_LT, FN_LTU, FN_SND
  } alu_func_e;

  typedef enum logic [2:0] {
    FWD_NONE, FWD_WB, FWD_MEM_ALU, FWD_MEM_SHIFT, FWD_MEM_LINK, FWD_MEM_IMM
  } fwd_sel_e;

  typedef enum logic {WAIT_START, RUN} run_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction word layout.
  typedef struct packed {
    logic                  w_imm;
    logic [REG_ADDR_W-1:0] addr_w;
    logic                  const_flag;
    logic                  a_imm;
    logic [REG_ADDR_W-1:0] addr_a;
    logic                  b_imm;
    logic [REG_ADDR_W-1:0] addr_b;
    logic [3:0]            func;
    logic [5:0]            opc;
  } instr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage payloads.
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       data_a;
    logic [XLEN-1:0]       data_b;
    logic [XLEN-1:0]       data_w;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] addr_a;
    logic [REG_ADDR_W-1:0] addr_b;
    logic [REG_ADDR_W-1:0] addr_w;
    logic                  a_dis;
    logic                  b_dis;
    logic                  w_dis;
    opcode_e               opc;
    alu_func_e             func;
  } id_ex_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       data_w;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       alu_res;
    logic [XLEN-1:0]       shift_res;
    logic [REG_ADDR_W-1:0] addr_w;
    opcode_e               opc;
    logic                  write_reg;
  } ex_mem_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
  } wb_t;

endpackage
